// File: aes_pkg.sv
package aes_pkg;

  // ********************
  // sizes.
  localparam int addr_width  = 4;
  localparam int data_width  = 32;
  localparam int block_width = 128;
  localparam int n_rounds    = 10;   // aes-128 only.

  // ********************
  // register map.
  // key, data and result take four words each, word 0 is the most significant.
  localparam logic [addr_width-1:0] reg_key0    = 4'd0;
  localparam logic [addr_width-1:0] reg_data0   = 4'd4;
  localparam logic [addr_width-1:0] reg_result0 = 4'd8;
  localparam logic [addr_width-1:0] reg_cmd     = 4'd12;  // bit 0 starts a run.
  localparam logic [addr_width-1:0] reg_status  = 4'd13;  // bit 0 busy, bit 1 done.

  // main fsm encoding.
  localparam logic [1:0] fsm_idle   = 2'd0;
  localparam logic [1:0] fsm_run    = 2'd1;
  localparam logic [1:0] fsm_finish = 2'd2;

  // one state word, seen as bytes or as columns.
  typedef union packed {
    logic [0:block_width/8-1][7:0]   bytes;  // byte i in aes input order.
    logic [0:block_width/32-1][31:0] cols;   // column c is bytes 4c to 4c+3.
  } aes_block_u;

  // ********************
  // forward s-box, row n covers inputs n*16 to n*16+15.
  localparam logic [0:255][7:0] sbox_table = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  function automatic logic [7:0] aes_sbox(input logic [7:0] b);
    return sbox_table[b];
  endfunction

  // multiply by x in gf(2^8), poly 0x11b.
  function automatic logic [7:0] aes_xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

endpackage

// File: aes_engine_if.sv
interface aes_engine_if;
  import aes_pkg::*;

  // request side.
  logic                   start;   // one-cycle pulse.
  logic [block_width-1:0] key;     // held from start until done.
  logic [block_width-1:0] block;

  // completion side.
  logic                   done;    // one-cycle pulse.
  logic [block_width-1:0] result;  // valid while done is high.

  modport ctrl (
    output start,
    output key,
    output block,
    input  done,
    input  result
  );

  modport engine (
    input  start,
    input  key,
    input  block,
    output done,
    output result
  );

endinterface

// File: aes_regfile.sv
module aes_regfile (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            periph_valid_i,
  output logic                            periph_ready_o,
  input  logic                            periph_we_i,
  input  logic [aes_pkg::addr_width-1:0]  periph_addr_i,
  input  logic [aes_pkg::data_width-1:0]  periph_wdata_i,
  output logic                            periph_rvalid_o,
  output logic [aes_pkg::data_width-1:0]  periph_rdata_o,
  input  logic                            busy_i,
  input  logic                            done_evt_i,
  input  logic [aes_pkg::block_width-1:0] result_i,
  output logic                            start_req_o,
  output logic [aes_pkg::block_width-1:0] key_o,
  output logic [aes_pkg::block_width-1:0] block_o,
  output logic                            evt_o
);
  import aes_pkg::*;

  logic [0:3][data_width-1:0] key_q;
  logic [0:3][data_width-1:0] data_q;
  logic [0:3][data_width-1:0] result_q;
  logic                       done_sticky_q;
  logic [addr_width-3:0]      grp;
  logic [1:0]                 word;
  logic                       is_key, is_data, is_result, is_cmd, is_status;
  logic                       hold, accept, wr, rd;

  // ********************
  // address decode.
  assign grp       = periph_addr_i[addr_width-1:2];
  assign word      = periph_addr_i[1:0];
  assign is_key    = (grp == reg_key0[addr_width-1:2]);
  assign is_data   = (grp == reg_data0[addr_width-1:2]);
  assign is_result = (grp == reg_result0[addr_width-1:2]);
  assign is_cmd    = (periph_addr_i == reg_cmd);
  assign is_status = (periph_addr_i == reg_status);

  // writes that touch engine inputs wait for the run to finish.
  assign hold = periph_we_i & (is_key | is_data | is_cmd) & (busy_i | start_req_o);

  assign periph_ready_o = ~hold;
  assign accept         = periph_valid_i & periph_ready_o;
  assign wr             = accept & periph_we_i;
  assign rd             = accept & ~periph_we_i;

  assign key_o   = key_q;
  assign block_o = data_q;

  // ********************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      key_q           <= '0;
      data_q          <= '0;
      result_q        <= '0;
      done_sticky_q   <= 1'b0;
      start_req_o     <= 1'b0;
      evt_o           <= 1'b0;
      periph_rvalid_o <= 1'b0;
    end else begin
      start_req_o     <= 1'b0;
      evt_o           <= done_evt_i;  // event leaves with the result capture.
      periph_rvalid_o <= rd;
      if (wr) begin
        if (is_key) begin
          key_q[word] <= periph_wdata_i;
        end else if (is_data) begin
          data_q[word] <= periph_wdata_i;
        end else if (is_cmd && periph_wdata_i[0]) begin
          start_req_o   <= 1'b1;
          done_sticky_q <= 1'b0;
        end
      end
      if (done_evt_i) begin
        result_q      <= result_i;
        done_sticky_q <= 1'b1;
      end
    end
  end

  // read data, one cycle after the accepting edge.
  always_ff @(posedge clk_i) begin
    if (rd) begin
      if (is_key)         periph_rdata_o <= key_q[word];
      else if (is_data)   periph_rdata_o <= data_q[word];
      else if (is_result) periph_rdata_o <= result_q[word];
      else if (is_status) periph_rdata_o <= {{(data_width-2){1'b0}}, done_sticky_q, busy_i};
      else                periph_rdata_o <= '0;  // command reads as zero.
    end
  end

endmodule

// File: aes_fsm.sv
module aes_fsm (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_req_i,
  input  logic engine_done_i,
  output logic engine_start_o,
  output logic busy_o,
  output logic done_evt_o
);
  import aes_pkg::*;

  logic [1:0] state_q;
  logic [1:0] state_d;

  // ********************
  // next state.
  always_comb begin
    state_d = state_q;
    case (state_q)
      fsm_idle: begin
        if (start_req_i) begin
          state_d = fsm_run;
        end
      end
      fsm_run: begin
        if (engine_done_i) begin
          state_d = fsm_finish;
        end
      end
      // one settling cycle, then back to idle.
      default: begin
        state_d = fsm_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q        <= fsm_idle;
      engine_start_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      engine_start_o <= (state_q == fsm_idle) & start_req_i;  // single pulse.
    end
  end

  // busy covers the whole engine run.
  assign busy_o = (state_q == fsm_run);

  // done event lines up with the engine done cycle.
  assign done_evt_o = (state_q == fsm_run) & engine_done_i;

endmodule

// File: aes_ctrl.sv
module aes_ctrl (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           periph_valid_i,
  output logic                           periph_ready_o,
  input  logic                           periph_we_i,
  input  logic [aes_pkg::addr_width-1:0] periph_addr_i,
  input  logic [aes_pkg::data_width-1:0] periph_wdata_i,
  output logic                           periph_rvalid_o,
  output logic [aes_pkg::data_width-1:0] periph_rdata_o,
  output logic                           evt_o,
  aes_engine_if.ctrl                     engine
);

  logic start_req;
  logic busy;
  logic done_evt;

  // ********************
  // peripheral slave and register file, also the event source.
  aes_regfile i_regfile (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .periph_valid_i  ( periph_valid_i  ),
    .periph_ready_o  ( periph_ready_o  ),
    .periph_we_i     ( periph_we_i     ),
    .periph_addr_i   ( periph_addr_i   ),
    .periph_wdata_i  ( periph_wdata_i  ),
    .periph_rvalid_o ( periph_rvalid_o ),
    .periph_rdata_o  ( periph_rdata_o  ),
    .busy_i          ( busy            ),
    .done_evt_i      ( done_evt        ),
    .result_i        ( engine.result   ),
    .start_req_o     ( start_req       ),
    .key_o           ( engine.key      ),
    .block_o         ( engine.block    ),
    .evt_o           ( evt_o           )
  );

  // main fsm.
  aes_fsm i_fsm (
    .clk_i          ( clk_i        ),
    .reset_i        ( reset_i      ),
    .start_req_i    ( start_req    ),
    .engine_done_i  ( engine.done  ),
    .engine_start_o ( engine.start ),
    .busy_o         ( busy         ),
    .done_evt_o     ( done_evt     )
  );

endmodule

// File: aes_key_sched.sv
module aes_key_sched (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            load_i,
  input  logic [aes_pkg::block_width-1:0] key_i,
  output aes_pkg::aes_block_u             round_key_o
);
  import aes_pkg::*;

  aes_block_u  rk_q;    // key of the round just done.
  logic [7:0]  rcon_q;
  logic [31:0] rot;
  logic [31:0] sub;
  logic [31:0] temp;

  // ********************
  // next round key from the stored one.
  always_comb begin
    rot = {rk_q.cols[3][23:0], rk_q.cols[3][31:24]};  // rotword.
    for (int i = 0; i < 4; i++) begin
      sub[8*i +: 8] = aes_sbox(rot[8*i +: 8]);
    end
    temp = sub ^ {rcon_q, 24'h000000};
    round_key_o.cols[0] = rk_q.cols[0] ^ temp;
    for (int c = 1; c < block_width/32; c++) begin
      round_key_o.cols[c] = rk_q.cols[c] ^ round_key_o.cols[c-1];
    end
  end

  // round key register.
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      rk_q <= key_i;
    end else begin
      rk_q <= round_key_o;
    end
  end

  // round constant, 01 for round 1 and doubled each round.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rcon_q <= 8'h01;
    end else if (load_i) begin
      rcon_q <= 8'h01;
    end else begin
      rcon_q <= aes_xtime(rcon_q);
    end
  end

endmodule

// File: aes_round.sv
module aes_round (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                load_i,
  input  aes_pkg::aes_block_u state_i,
  output aes_pkg::aes_block_u round_out_o,
  output logic                last_o
);
  import aes_pkg::*;

  logic [3:0] round_q;  // 0 when idle, else the round being computed.
  aes_block_u sub_s;
  aes_block_u shift_s;
  aes_block_u mix_s;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      round_q <= 4'd0;
    end else if (load_i) begin
      round_q <= 4'd1;
    end else if (last_o) begin
      round_q <= 4'd0;
    end else if (round_q != 4'd0) begin
      round_q <= round_q + 4'd1;
    end
  end

  assign last_o = (round_q == 4'(n_rounds));

  // ********************
  // subbytes then shiftrows, row r moves left by r columns.
  always_comb begin
    for (int i = 0; i < block_width/8; i++) begin
      sub_s.bytes[i] = aes_sbox(state_i.bytes[i]);
    end
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift_s.bytes[4*c+r] = sub_s.bytes[4*((c+r)%4)+r];
      end
    end
  end

  // mixcolumns, one column at a time.
  always_comb begin
    logic [7:0] a0, a1, a2, a3, t;
    for (int c = 0; c < block_width/32; c++) begin
      {a0, a1, a2, a3} = shift_s.cols[c];
      t = a0 ^ a1 ^ a2 ^ a3;
      mix_s.cols[c] = {a0 ^ t ^ aes_xtime(a0 ^ a1), a1 ^ t ^ aes_xtime(a1 ^ a2),
                       a2 ^ t ^ aes_xtime(a2 ^ a3), a3 ^ t ^ aes_xtime(a3 ^ a0)};
    end
  end

  assign round_out_o = last_o ? shift_s : mix_s;  // final round skips mixcolumns.

endmodule

// File: aes_core.sv
module aes_core (
  input  logic         clk_i,
  input  logic         reset_i,
  aes_engine_if.engine engine
);
  import aes_pkg::*;

  aes_block_u state_q;
  aes_block_u round_key;
  aes_block_u round_out;
  logic       last;
  logic       run_q;
  logic       done_q;

  // ********************
  aes_key_sched i_key_sched (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .load_i      ( engine.start ),
    .key_i       ( engine.key   ),
    .round_key_o ( round_key    )
  );

  aes_round i_round (
    .clk_i       ( clk_i        ),
    .reset_i     ( reset_i      ),
    .load_i      ( engine.start ),
    .state_i     ( state_q      ),
    .round_out_o ( round_out    ),
    .last_o      ( last         )
  );

  // state register, holds the ciphertext once the run ends.
  always_ff @(posedge clk_i) begin
    if (engine.start) begin
      state_q <= engine.block ^ engine.key;  // initial addroundkey.
    end else if (run_q) begin
      state_q <= round_out ^ round_key;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      run_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      run_q  <= engine.start | (run_q & ~last);
      done_q <= run_q & last;
    end
  end

  assign engine.done   = done_q;
  assign engine.result = state_q;

endmodule

// File: aes_top.sv
module aes_top (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           periph_valid_i,
  output logic                           periph_ready_o,
  input  logic                           periph_we_i,
  input  logic [aes_pkg::addr_width-1:0] periph_addr_i,
  input  logic [aes_pkg::data_width-1:0] periph_wdata_i,
  output logic                           periph_rvalid_o,
  output logic [aes_pkg::data_width-1:0] periph_rdata_o,
  output logic                           evt_o
);

  // control to engine link.
  aes_engine_if engine_if ();

  // ********************
  aes_ctrl i_ctrl (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .periph_valid_i  ( periph_valid_i  ),
    .periph_ready_o  ( periph_ready_o  ),
    .periph_we_i     ( periph_we_i     ),
    .periph_addr_i   ( periph_addr_i   ),
    .periph_wdata_i  ( periph_wdata_i  ),
    .periph_rvalid_o ( periph_rvalid_o ),
    .periph_rdata_o  ( periph_rdata_o  ),
    .evt_o           ( evt_o           ),
    .engine          ( engine_if       )
  );

  // iterative engine, one round per cycle.
  aes_core i_core (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .engine  ( engine_if )
  );

endmodule

// File: aes_tb.sv
module aes_tb;
  import aes_pkg::*;

  // ********************
  // cycle budget for the watchdog.
  localparam int reset_cycles    = 8;
  localparam int bus_op_cycles   = 3;   // drive, accept, response.
  localparam int run_cycles      = 16;
  localparam int n_bus_ops       = 81;
  localparam int n_runs          = 5;
  localparam int event_timeout   = 40;
  localparam int watchdog_cycles = 2 * (reset_cycles + n_bus_ops * bus_op_cycles
                                        + n_runs * run_cycles);

  // fips-197 appendix c.1 and appendix b.
  localparam logic [127:0] key_c1 = 128'h000102030405060708090a0b0c0d0e0f;
  localparam logic [127:0] pt_c1  = 128'h00112233445566778899aabbccddeeff;
  localparam logic [127:0] ct_c1  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam logic [127:0] key_b  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam logic [127:0] pt_b   = 128'h3243f6a8885a308d313198a2e0370734;
  localparam logic [127:0] ct_b   = 128'h3925841d02dc09fbdc118597196a0b32;
  // another block under the appendix b key, sp 800-38a ecb vector 1.
  localparam logic [127:0] pt_ecb = 128'h6bc1bee22e409f96e93d7e117393172a;
  localparam logic [127:0] ct_ecb = 128'h3ad77bb40d7a3660a89ecaf32466ef97;

  logic                  clk;
  logic                  reset;
  logic                  periph_valid;
  logic                  periph_ready_o;
  logic                  periph_we;
  logic [addr_width-1:0] periph_addr;
  logic [data_width-1:0] periph_wdata;
  logic                  periph_rvalid_o;
  logic [data_width-1:0] periph_rdata_o;
  logic                  evt_o;

  string       test_name;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  int          write_stalls;   // edges the last write waited.
  logic [31:0] lfsr_q;

  aes_top u_dut (
    .clk_i           ( clk             ),
    .reset_i         ( reset           ),
    .periph_valid_i  ( periph_valid    ),
    .periph_ready_o  ( periph_ready_o  ),
    .periph_we_i     ( periph_we       ),
    .periph_addr_i   ( periph_addr     ),
    .periph_wdata_i  ( periph_wdata    ),
    .periph_rvalid_o ( periph_rvalid_o ),
    .periph_rdata_o  ( periph_rdata_o  ),
    .evt_o           ( evt_o           )
  );

  always #5 clk = ~clk;

  // ********************
  // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      w[i]   = lfsr_q[0];  // one bit per step.
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: passed", test_name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic check_equal(input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch %s: expected %h, actual %h", test_name, expected, actual);
      test_errors++;
    end
  endtask

  // ********************
  // bus tasks start and end on a falling edge.
  task automatic bus_write(input logic [addr_width-1:0] addr, input logic [31:0] data);
    logic accepted;
    accepted     = 1'b0;
    write_stalls = 0;
    periph_valid = 1'b1;
    periph_we    = 1'b1;
    periph_addr  = addr;
    periph_wdata = data;
    while (!accepted) begin
      @(posedge clk);
      accepted = periph_ready_o;  // ready as seen by this edge.
      if (!accepted) begin
        write_stalls++;
      end
    end
    @(negedge clk);
    periph_valid = 1'b0;
    periph_we    = 1'b0;
  endtask

  task automatic bus_read(input logic [addr_width-1:0] addr, output logic [31:0] data);
    periph_valid = 1'b1;
    periph_we    = 1'b0;
    periph_addr  = addr;
    @(posedge clk);
    assert (periph_ready_o) else begin
      $display("%s: read at address %0d was not accepted", test_name, addr);
      test_errors++;
    end
    @(negedge clk);
    periph_valid = 1'b0;
    assert (periph_rvalid_o) else begin
      $display("%s: no read response for address %0d", test_name, addr);
      test_errors++;
    end
    data = periph_rdata_o;
  endtask

  task automatic write_block(input logic [addr_width-1:0] base, input logic [127:0] value);
    for (int i = 0; i < 4; i++) begin
      bus_write(base + 4'(i), value[127-32*i -: 32]);  // word 0 is the top word.
    end
  endtask

  task automatic check_block(input logic [addr_width-1:0] base, input logic [127:0] expected);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      bus_read(base + 4'(i), w);
      check_equal(expected[127-32*i -: 32], w);
    end
  endtask

  // counts cycles from the command edge until evt_o is seen.
  task automatic wait_event(output int latency);
    latency = 0;
    while (!evt_o && latency < event_timeout) begin
      @(negedge clk);
      latency++;
    end
    assert (evt_o) else begin
      $display("%s: no done event within %0d cycles", test_name, event_timeout);
      test_errors++;
    end
    @(negedge clk);
    assert (!evt_o) else begin
      $display("%s: done event lasted more than one cycle", test_name);
      test_errors++;
    end
  endtask

  // ********************
  task automatic check_reset_state();
    logic [31:0] w;
    start_test("reset_state");
    assert (periph_ready_o && !periph_rvalid_o && !evt_o) else begin
      $display("%s: ready, rvalid or evt_o has the wrong level after reset", test_name);
      test_errors++;
    end
    bus_read(reg_status, w);
    check_equal(32'h0, w);
    check_block(reg_result0, '0);
    finish_test();
  endtask

  task automatic check_register_readback();
    logic [31:0] vals [8];
    logic [31:0] w;
    start_test("register_readback");
    for (int i = 0; i < 8; i++) begin
      random_word(vals[i]);
      bus_write(reg_key0 + 4'(i), vals[i]);  // key words, then data words.
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(reg_key0 + 4'(i), w);
      check_equal(vals[i], w);
    end
    check_block(reg_result0, '0);
    finish_test();
  endtask

  task automatic encrypt_vector(input string name, input logic [127:0] key,
                                input logic [127:0] pt, input logic [127:0] ct);
    int          latency;
    logic [31:0] w;
    start_test(name);
    write_block(reg_key0, key);
    write_block(reg_data0, pt);
    bus_write(reg_cmd, 32'h1);
    wait_event(latency);
    check_equal(32'd13, latency);
    bus_read(reg_status, w);
    check_equal(32'h2, w);  // done, not busy.
    check_block(reg_result0, ct);
    finish_test();
  endtask

  task automatic exercise_back_pressure();
    logic [31:0] held;
    logic [31:0] w;
    start_test("back_pressure");
    bus_write(reg_cmd, 32'h1);
    @(negedge clk);
    bus_read(reg_status, w);  // accepted on edge 2.
    check_equal(32'h1, w);
    random_word(held);
    // first offered on edge 3, busy holds it through edge 13.
    bus_write(reg_data0 + 4'd3, held);
    check_equal(32'd11, 32'(write_stalls));
    bus_read(reg_status, w);
    check_equal(32'h2, w);
    bus_read(reg_data0 + 4'd3, w);
    check_equal(held, w);
    check_block(reg_result0, ct_b);
    finish_test();
  endtask

  task automatic reuse_key();
    int          latency;
    logic [31:0] w;
    start_test("key_reuse");
    write_block(reg_data0, pt_b);
    bus_write(reg_cmd, 32'h1);
    write_block(reg_data0, pt_ecb);  // lands once the first run ends.
    bus_read(reg_status, w);
    check_equal(32'h2, w);
    check_block(reg_result0, ct_b);
    bus_write(reg_cmd, 32'h1);
    wait_event(latency);
    check_equal(32'd13, latency);
    check_block(reg_result0, ct_ecb);
    finish_test();
  endtask

  // ********************
  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    periph_valid = 1'b0;
    periph_we    = 1'b0;
    periph_addr  = '0;
    periph_wdata = '0;
    lfsr_q       = 32'haf89;
    tests_passed = 0;
    tests_failed = 0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_reset_state();
    check_register_readback();
    encrypt_vector("appendix_c1", key_c1, pt_c1, ct_c1);
    encrypt_vector("appendix_b", key_b, pt_b, ct_b);
    exercise_back_pressure();
    reuse_key();
    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog.
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: build.f
aes_pkg.sv
aes_engine_if.sv
aes_regfile.sv
aes_fsm.sv
aes_ctrl.sv
aes_key_sched.sv
aes_round.sv
aes_core.sv
aes_top.sv
aes_tb.sv

// File: Makefile
TOP = aes_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx 'Test OK'

clean:
	rm -rf obj_dir

.PHONY: sim clean
